// ==== ahbLite_consts.svh ====
`ifndef AHBLITE_CONSTS_SVH
`define AHBLITE_CONSTS_SVH

// number of slave ports behind the mux
`define AHB_NUM_SLAVES 3

// port index of each slave in the select vector
`define AHB_SLV_SRAM 0
`define AHB_SLV_CFG 1
`define AHB_SLV_DEFAULT 2

// sram region, word addressed, 1 KB
`define AHB_SRAM_BASE 32'h0000_0000
`define AHB_SRAM_WORDS 256

// config register region, four word slots
`define AHB_CFG_BASE 32'h4000_0000
`define AHB_CFG_BYTES 16

// value of the read-only id register
`define AHB_CFG_ID 32'hA4B1_0001

`endif

// ==== ahbLitePkg.sv ====
`include "ahbLite_consts.svh"

package ahbLitePkg;

    // htrans encoding per AMBA AHB-Lite
    typedef enum logic [1:0]
    {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htransT;

    // master side, address phase plus write data of the data phase
    typedef struct packed
    {
        logic [31:0] haddr;
        htransT      htrans;
        logic        hwrite;
        // only word size is supported
        logic [2:0]  hsize;
        logic [31:0] hwdata;
    } ahbReqT;

    // one slave's data phase reply
    typedef struct packed
    {
        logic        hreadyout;
        logic        hresp;
        logic [31:0] hrdata;
    } ahbRspT;

    // one-hot slave select, bit index is the port number
    typedef logic [`AHB_NUM_SLAVES-1:0] slvSelT;

endpackage

// ==== ahbLiteDecoder.sv ====
`timescale 1ns/100ps
`include "ahbLite_consts.svh"

module ahbLiteDecoder
(
    input  ahbLitePkg::ahbReqT  req,
    output ahbLitePkg::slvSelT  sel
);

    // region masks keep only the bits above each region's size
    localparam logic [31:0] sramMask = ~(32'(`AHB_SRAM_WORDS * 4) - 32'd1);
    localparam logic [31:0] cfgMask  = ~(32'(`AHB_CFG_BYTES) - 32'd1);

    logic sramHit;
    logic cfgHit;

    // compare upper address bits against each base
    assign sramHit = (req.haddr & sramMask) == `AHB_SRAM_BASE;
    assign cfgHit  = (req.haddr & cfgMask) == `AHB_CFG_BASE;

    // exactly one bit set, default slave catches the rest
    always_comb
    begin
        sel = '0;
        if (sramHit)
        begin
            sel[`AHB_SLV_SRAM] = 1'b1;
        end
        else if (cfgHit)
        begin
            sel[`AHB_SLV_CFG] = 1'b1;
        end
        else
        begin
            sel[`AHB_SLV_DEFAULT] = 1'b1;
        end
    end

endmodule

// ==== ahbLiteSlaveMux.sv ====
`timescale 1ns/100ps
`include "ahbLite_consts.svh"

module ahbLiteSlaveMux
(
    input  logic               HCLK,
    input  logic               HRESETn,
    input  logic               hready,
    input  ahbLitePkg::slvSelT sel,
    input  ahbLitePkg::ahbRspT slvRsp [`AHB_NUM_SLAVES],
    output logic               HREADYOUT,
    output logic               HRESP,
    output logic [31:0]        HRDATA
);

    import ahbLitePkg::*;

    // select of the transfer now in its data phase
    slvSelT      selReg;
    logic        readyOr;
    logic        respOr;
    logic [31:0] dataOr;

    // capture the address phase select only when the bus moves on
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            selReg <= '0;
        end
        else if (hready)
        begin
            selReg <= sel;
        end
    end

    // one-hot AND-OR select, unselected ports contribute zero
    always_comb
    begin
        readyOr = 1'b0;
        respOr  = 1'b0;
        dataOr  = '0;
        for (int i = 0; i < `AHB_NUM_SLAVES; i++)
        begin
            readyOr = readyOr | (selReg[i] & slvRsp[i].hreadyout);
            respOr  = respOr | (selReg[i] & slvRsp[i].hresp);
            dataOr  = dataOr | ({32{selReg[i]}} & slvRsp[i].hrdata);
        end
    end

    // nothing latched, so answer ready and OKAY
    assign HREADYOUT = (selReg == '0) ? 1'b1 : readyOr;
    // resp and data already fall to zero with no select
    assign HRESP     = respOr;
    assign HRDATA    = dataOr;

endmodule

// ==== ahbLiteSram.sv ====
`timescale 1ns/100ps
`include "ahbLite_consts.svh"

module ahbLiteSram
(
    input  logic               HCLK,
    input  logic               HRESETn,
    input  ahbLitePkg::ahbReqT req,
    input  logic               hsel,
    input  logic               hready,
    input  logic [1:0]         waitStates,
    output ahbLitePkg::ahbRspT rsp
);

    import ahbLitePkg::*;

    localparam int addrBits = $clog2(`AHB_SRAM_WORDS);

    logic [31:0]         mem [`AHB_SRAM_WORDS];
    // data phase control
    logic                active;
    logic [1:0]          waitCnt;
    // data phase payload, captured with the address phase
    logic                isWrite;
    logic [addrBits-1:0] addrReg;
    logic                start;
    logic                lastCycle;

    // valid transfer accepted this edge
    assign start = hsel && hready && (req.htrans == NONSEQ || req.htrans == SEQ);
    // final data phase cycle, wait count used up
    assign lastCycle = active && (waitCnt == 2'd0);

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            active  <= 1'b0;
            waitCnt <= 2'd0;
        end
        else if (hready)
        begin
            // wait setting sampled here, later cfg writes do not touch it
            active  <= start;
            waitCnt <= start ? waitStates : 2'd0;
        end
        else if (waitCnt != 2'd0)
        begin
            waitCnt <= waitCnt - 2'd1;
        end
    end

    // word index only, byte lanes ignored
    always_ff @(posedge HCLK)
    begin
        if (start)
        begin
            isWrite <= req.hwrite;
            addrReg <= req.haddr[addrBits+1:2];
        end
    end

    // write data arrives in the data phase, commit at its end
    always_ff @(posedge HCLK)
    begin
        if (lastCycle && isWrite && hready)
        begin
            mem[addrReg] <= req.hwdata;
        end
    end

    // stall until the counter runs out
    assign rsp.hreadyout = !active || (waitCnt == 2'd0);
    // sram never errors
    assign rsp.hresp     = 1'b0;
    // read word only in the completing cycle
    assign rsp.hrdata    = (lastCycle && !isWrite) ? mem[addrReg] : 32'd0;

endmodule

// ==== ahbLiteCfgRegs.sv ====
`timescale 1ns/100ps
`include "ahbLite_consts.svh"

module ahbLiteCfgRegs
(
    input  logic               HCLK,
    input  logic               HRESETn,
    input  ahbLitePkg::ahbReqT req,
    input  logic               hsel,
    input  logic               hready,
    output ahbLitePkg::ahbRspT rsp,
    output logic [1:0]         waitStates
);

    import ahbLitePkg::*;

    // word slot within the 16 byte region
    localparam logic [1:0] offWait    = 2'd0;
    localparam logic [1:0] offScratch = 2'd1;
    localparam logic [1:0] offId      = 2'd2;

    logic        active;
    logic        isWrite;
    logic [1:0]  offReg;
    logic [1:0]  waitReg;
    logic [31:0] scratchReg;
    logic        start;

    assign start = hsel && hready && (req.htrans == NONSEQ || req.htrans == SEQ);

    // data phase tracking, always one cycle
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            active <= 1'b0;
        end
        else if (hready)
        begin
            active <= start;
        end
    end

    always_ff @(posedge HCLK)
    begin
        if (start)
        begin
            isWrite <= req.hwrite;
            offReg  <= req.haddr[3:2];
        end
    end

    // register update at the end of the write data phase
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            waitReg    <= 2'd0;
            scratchReg <= 32'd0;
        end
        else if (active && isWrite && hready)
        begin
            case (offReg)
                // only the low two bits are kept
                offWait:    waitReg    <= req.hwdata[1:0];
                offScratch: scratchReg <= req.hwdata;
                // id and the unused slot ignore writes
                default:    ;
            endcase
        end
    end

    // read mux, zero outside a read data phase
    always_comb
    begin
        rsp.hrdata = 32'd0;
        if (active && !isWrite)
        begin
            case (offReg)
                offWait:    rsp.hrdata = {30'd0, waitReg};
                offScratch: rsp.hrdata = scratchReg;
                offId:      rsp.hrdata = `AHB_CFG_ID;
                default:    rsp.hrdata = 32'd0;
            endcase
        end
    end

    // zero wait, always OKAY
    assign rsp.hreadyout = 1'b1;
    assign rsp.hresp     = 1'b0;

    // drives the sram wait counter load
    assign waitStates = waitReg;

endmodule

// ==== ahbLiteDefaultSlave.sv ====
`timescale 1ns/100ps

module ahbLiteDefaultSlave
(
    input  logic               HCLK,
    input  logic               HRESETn,
    input  ahbLitePkg::ahbReqT req,
    input  logic               hsel,
    input  logic               hready,
    output ahbLitePkg::ahbRspT rsp
);

    import ahbLitePkg::*;

    // idle, then the two cycles of an ERROR response
    typedef enum logic [1:0]
    {
        DS_IDLE = 2'd0,
        DS_ERR1 = 2'd1,
        DS_ERR2 = 2'd2
    } dsStateT;

    dsStateT state;
    logic    start;

    // IDLE and BUSY fall through to the plain OKAY path
    assign start = hsel && hready && (req.htrans == NONSEQ || req.htrans == SEQ);

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            state <= DS_IDLE;
        end
        else
        begin
            case (state)
                DS_ERR1: state <= DS_ERR2;
                // second error cycle may overlap a new unmapped access
                default: state <= start ? DS_ERR1 : DS_IDLE;
            endcase
        end
    end

    // first error cycle holds the bus, second releases it
    assign rsp.hreadyout = (state != DS_ERR1);
    assign rsp.hresp     = (state == DS_ERR1) || (state == DS_ERR2);
    assign rsp.hrdata    = 32'd0;

endmodule

// ==== ahbLiteSubsystem.sv ====
`timescale 1ns/100ps
`include "ahbLite_consts.svh"

module ahbLiteSubsystem
(
    input  logic               HCLK,
    input  logic               HRESETn,
    input  ahbLitePkg::ahbReqT req,
    output logic               HREADY,
    output logic               HRESP,
    output logic [31:0]        HRDATA
);

    import ahbLitePkg::*;

    slvSelT     sel;
    ahbRspT     slvRsp [`AHB_NUM_SLAVES];
    logic [1:0] waitStates;

    // address phase select
    ahbLiteDecoder i_decoder
    (
        .req (req),
        .sel (sel)
    );

    ahbLiteSram i_sram
    (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .req        (req),
        .hsel       (sel[`AHB_SLV_SRAM]),
        .hready     (HREADY),
        .waitStates (waitStates),
        .rsp        (slvRsp[`AHB_SLV_SRAM])
    );

    // wait setting for the sram comes from here
    ahbLiteCfgRegs i_cfgRegs
    (
        .HCLK       (HCLK),
        .HRESETn    (HRESETn),
        .req        (req),
        .hsel       (sel[`AHB_SLV_CFG]),
        .hready     (HREADY),
        .rsp        (slvRsp[`AHB_SLV_CFG]),
        .waitStates (waitStates)
    );

    ahbLiteDefaultSlave i_defaultSlave
    (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .req     (req),
        .hsel    (sel[`AHB_SLV_DEFAULT]),
        .hready  (HREADY),
        .rsp     (slvRsp[`AHB_SLV_DEFAULT])
    );

    // mux output is the bus HREADY, fed back to all slaves
    ahbLiteSlaveMux i_slaveMux
    (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .hready    (HREADY),
        .sel       (sel),
        .slvRsp    (slvRsp),
        .HREADYOUT (HREADY),
        .HRESP     (HRESP),
        .HRDATA    (HRDATA)
    );

endmodule

// ==== ahbLite_properties.sv ====
`timescale 1ns/100ps

module ahbLiteSlaveMuxProps
(
    input logic               HCLK,
    input logic               HRESETn,
    input ahbLitePkg::slvSelT selReg,
    input logic               HREADYOUT,
    input logic               HRESP
);

    // failure tallies, one per property
    int failOneHot = 0;
    int failErrPair = 0;
    int failResetReady = 0;
    int failCount;

    assign failCount = failOneHot + failErrPair + failResetReady;

    // latched select names at most one slave
    selOneHot: assert property (@(posedge HCLK) disable iff (!HRESETn) $onehot0(selReg))
    else
    begin
        failOneHot = failOneHot + 1;
        $error("slave mux select register is not one-hot or zero");
    end

    // first ERROR cycle stalls, second one releases
    errTwoCycle: assert property (@(posedge HCLK) disable iff (!HRESETn)
        (HRESP && !HREADYOUT) |=> (HRESP && HREADYOUT))
    else
    begin
        failErrPair = failErrPair + 1;
        $error("ERROR response not followed by its completing cycle");
    end

    // bus idle and ready right out of reset
    readyAfterReset: assert property (@(posedge HCLK) $rose(HRESETn) |-> HREADYOUT)
    else
    begin
        failResetReady = failResetReady + 1;
        $error("HREADYOUT low in the first cycle after reset");
    end

endmodule

bind ahbLiteSlaveMux ahbLiteSlaveMuxProps i_props
(
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .selReg    (selReg),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP)
);

// ==== tbAhbLite.sv ====
`timescale 1ns/100ps
`include "ahbLite_consts.svh"

module tbAhbLite;

    import ahbLitePkg::*;

    localparam int numRandOps = 200;
    // each transfer at most 3 wait states plus its final cycle
    localparam int timeoutCycles = 8 + (2 * numRandOps + 64) * 4 + 100;

    // transfer whose data phase is still open
    typedef struct packed
    {
        logic        valid;
        logic [31:0] addr;
        htransT      trans;
        logic        write;
        logic [31:0] wdata;
        logic [1:0]  expWait;
    } pendT;

    logic        HCLK;
    logic        HRESETn;
    ahbReqT      req;
    logic        HREADY;
    logic        HRESP;
    logic [31:0] HRDATA;

    // reference model
    logic [31:0] memModel [`AHB_SRAM_WORDS];
    logic        written [`AHB_SRAM_WORDS];
    logic [1:0]  waitModel;
    logic [31:0] scratchModel;
    pendT        pend;
    int          seed = 32'h538d_1f29;

    ahbLiteSubsystem i_dut
    (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .req     (req),
        .HREADY  (HREADY),
        .HRESP   (HRESP),
        .HRDATA  (HRDATA)
    );

    initial
    begin
        HCLK = 1'b0;
        forever #5 HCLK = ~HCLK;
    end

    // watchdog bound from the transfer count
    initial
    begin
        #(timeoutCycles * 10);
        $display("watchdog expired, the bus stopped completing transfers");
        $display("Testbench failed");
        $fatal(1, "timeout");
    end

    function automatic logic [31:0] randWord();
        return $random(seed);
    endfunction

    function automatic logic [31:0] sramAddr(input logic [7:0] idx);
        return `AHB_SRAM_BASE + {22'd0, idx, 2'b00};
    endfunction

    // address map from the master's view
    // unsigned offset covers both bounds of each region
    function automatic int regionOf(input logic [31:0] addr);
        if ((addr - `AHB_SRAM_BASE) < 32'(`AHB_SRAM_WORDS * 4))
            return `AHB_SLV_SRAM;
        if ((addr - `AHB_CFG_BASE) < 32'(`AHB_CFG_BYTES))
            return `AHB_SLV_CFG;
        return `AHB_SLV_DEFAULT;
    endfunction

    function automatic logic [31:0] cfgRead(input logic [1:0] off);
        case (off)
            2'd0: return {30'd0, waitModel};
            2'd1: return scratchModel;
            2'd2: return `AHB_CFG_ID;
            default: return 32'd0;
        endcase
    endfunction

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp)
        begin
            $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
            $display("Testbench failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // new address phase overlapped with the open data phase
    task automatic transfer(input logic [31:0] addr, input htransT trans, input logic write,
                            input logic [31:0] wdata);
        logic [1:0]  newWait;
        logic        act;
        logic        expResp;
        logic [31:0] expData;
        int          region;
        int          expWaits;
        int          lowCycles;
        // sram samples the wait register before the open write lands
        newWait  = waitModel;
        region   = regionOf(pend.addr);
        act      = pend.valid && (pend.trans == NONSEQ || pend.trans == SEQ);
        expResp  = act && region == `AHB_SLV_DEFAULT;
        expWaits = 0;
        if (act && region == `AHB_SLV_SRAM)
            expWaits = int'(pend.expWait);
        else if (expResp)
            expWaits = 1;
        expData = 32'd0;
        if (act && !pend.write && region == `AHB_SLV_SRAM)
            expData = memModel[pend.addr[9:2]];
        else if (act && !pend.write && region == `AHB_SLV_CFG)
            expData = cfgRead(pend.addr[3:2]);
        @(negedge HCLK);
        req.haddr  = addr;
        req.htrans = trans;
        req.hwrite = write;
        req.hwdata = pend.wdata;
        // address held while the slave stalls
        lowCycles = 0;
        while (HREADY !== 1'b1)
        begin
            checkEq(32'(HRESP), 32'(expResp), "HRESP in wait state");
            lowCycles++;
            @(negedge HCLK);
        end
        checkEq(lowCycles, expWaits, "wait state count");
        checkEq(32'(HRESP), 32'(expResp), "HRESP at completion");
        checkEq(HRDATA, expData, "HRDATA at completion");
        if (act && pend.write && region == `AHB_SLV_SRAM)
            memModel[pend.addr[9:2]] = pend.wdata;
        if (act && pend.write && region == `AHB_SLV_CFG && pend.addr[3:2] == 2'd0)
            waitModel = pend.wdata[1:0];
        if (act && pend.write && region == `AHB_SLV_CFG && pend.addr[3:2] == 2'd1)
            scratchModel = pend.wdata;
        pend = '{1'b1, addr, trans, write, wdata, newWait};
    endtask

    task automatic ahbWrite(input logic [31:0] addr, input logic [31:0] data);
        transfer(addr, NONSEQ, 1'b1, data);
    endtask

    task automatic ahbRead(input logic [31:0] addr);
        transfer(addr, NONSEQ, 1'b0, 32'd0);
    endtask

    initial
    begin
        logic [31:0] rnd;
        logic [31:0] bad;
        logic [7:0]  idx;
        HRESETn      = 1'b0;
        req          = '0;
        // word transfers only
        req.hsize    = 3'b010;
        pend         = '0;
        waitModel    = 2'd0;
        scratchModel = 32'd0;
        for (int i = 0; i < `AHB_SRAM_WORDS; i++)
            written[i] = 1'b0;
        repeat (8) @(posedge HCLK);
        @(negedge HCLK);
        HRESETn = 1'b1;
        checkEq(32'(HREADY), 32'd1, "HREADY after reset");
        checkEq(32'(HRESP), 32'd0, "HRESP after reset");
        checkEq(HRDATA, 32'd0, "HRDATA after reset");

        // random mix where reads only hit words already written
        for (int n = 0; n < numRandOps; n++)
        begin
            rnd = randWord();
            idx = rnd[15:8];
            if (rnd[2:0] == 3'd7)
                ahbWrite(`AHB_CFG_BASE, randWord());
            else if (rnd[2] && written[idx])
                ahbRead(sramAddr(idx));
            else
            begin
                written[idx] = 1'b1;
                ahbWrite(sramAddr(idx), randWord());
            end
            // occasional idle gap between otherwise back to back transfers
            if (rnd[5:4] == 2'd0)
                transfer(randWord(), IDLE, rnd[6], randWord());
        end

        // register readback including the id and the unused slot
        ahbWrite(`AHB_CFG_BASE, randWord());
        ahbRead(`AHB_CFG_BASE);
        ahbWrite(`AHB_CFG_BASE + 32'd4, randWord());
        ahbRead(`AHB_CFG_BASE + 32'd4);
        ahbWrite(`AHB_CFG_BASE + 32'd8, randWord());
        ahbRead(`AHB_CFG_BASE + 32'd8);
        ahbRead(`AHB_CFG_BASE + 32'd12);

        // every wait setting with random upper bits that the register drops
        for (int k = 0; k < 4; k++)
        begin
            rnd = randWord();
            idx = rnd[15:8];
            ahbWrite(`AHB_CFG_BASE, {rnd[31:2], 2'(k)});
            written[idx] = 1'b1;
            ahbWrite(sramAddr(idx), randWord());
            ahbRead(sramAddr(idx));
        end

        // unmapped accesses followed by a sram read
        bad = randWord();
        if (regionOf(bad) != `AHB_SLV_DEFAULT)
            bad = bad | 32'h8000_0000;
        ahbRead(bad);
        ahbWrite(bad, randWord());
        ahbRead(sramAddr(idx));

        // idle with write set must leave state alone
        transfer(sramAddr(idx), IDLE, 1'b1, randWord());
        transfer(`AHB_CFG_BASE, IDLE, 1'b1, randWord());
        transfer(`AHB_CFG_BASE + 32'd4, IDLE, 1'b1, randWord());
        transfer(bad, IDLE, 1'b0, 32'd0);
        ahbRead(sramAddr(idx));
        ahbRead(`AHB_CFG_BASE);
        ahbRead(`AHB_CFG_BASE + 32'd4);
        // closes the last data phase
        transfer(32'd0, IDLE, 1'b0, 32'd0);

        if (i_dut.i_slaveMux.i_props.failCount == 0)
        begin
            $display("Testbench passed");
            $finish;
        end
        else
        begin
            $display("%0d assertion failures on the slave mux",
                     i_dut.i_slaveMux.i_props.failCount);
            $display("Testbench failed");
            $fatal(1, "assertion failures on the slave mux");
        end
    end

endmodule

// ==== all.f ====
+incdir+.
ahbLitePkg.sv
ahbLiteDecoder.sv
ahbLiteSlaveMux.sv
ahbLiteSram.sv
ahbLiteCfgRegs.sv
ahbLiteDefaultSlave.sv
ahbLiteSubsystem.sv
ahbLite_properties.sv
tbAhbLite.sv

// ==== run.sh ====
#!/bin/sh
# build and run the AHB-Lite testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbAhbLite -f all.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/VtbAhbLite 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
